/* flist.f */
hw/mfifoPkg.sv
hw/dataRam.sv
hw/rrArbiter.sv
hw/pushCreditCtrl.sv
hw/linkedListMgr.sv
hw/popStagingCtrl.sv
hw/sharedMultiFifo.sv
tests/sharedMultiFifo_assertions.sv
tests/sharedMultiFifoTb.sv

/* run.sh */
#!/bin/sh
# Builds the shared multi-FIFO testbench with Verilator and runs it.
# Exits nonzero when the build fails, the simulation fails, or the pass line is missing.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f flist.f --top-module sharedMultiFifoTb -Mdir obj_dir -o simv
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/simv)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q '^=== PASS ===$'; then
  exit 0
fi
echo "Pass line not found in simulation output"
exit 1

/* tests/sharedMultiFifoTb.sv */
`timescale 1ns/1ps

module sharedMultiFifoTb
  import mfifoPkg::*;
();

  localparam int NumRows = 5;
  // How a row picks the target FIFO of each push
  localparam int SelFixed = 0;
  localparam int SelRandom = 1;
  localparam int SelCycle = 2;
  // How a row drives popReady
  localparam int ReadyAlways = 0;
  localparam int ReadyNever = 1;
  localparam int ReadyRandom = 2;

  // Stimulus table with one column per array, applied row by row
  string rowName [NumRows] = '{"singleOrder", "interleaved", "fill", "noDrainBurst",
                               "finalDrain"};
  int rowPushes [NumRows] = '{12, 40, 20, 24, 30};
  int rowSel [NumRows] = '{SelFixed, SelRandom, SelCycle, SelRandom, SelRandom};
  int rowFixedId [NumRows] = '{2, 0, 0, 0, 0};
  int rowReady [NumRows] = '{ReadyAlways, ReadyRandom, ReadyNever, ReadyRandom, ReadyAlways};
  bit rowDrain [NumRows] = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b1};

  logic clk;
  logic rst;
  pushReqT push;
  logic pushCredit;
  logic pushFull;
  logic receiverInReset;
  logic [NumFifos-1:0] popValid;
  logic [NumFifos-1:0] popReady;
  logic [NumFifos-1:0][Width-1:0] popData;

  logic [31:0] lcgState = 32'he951b218;
  // Expected words per FIFO in push order
  logic [Width-1:0] refQ [NumFifos][$];
  // Credits the sender holds right now
  int credits;
  int totalPushes;
  int totalCredits;
  int rowCredits;
  int checks;
  int errors;
  int testsRun;
  int failedTests;
  string curTest;
  // Stages that were stalled in the last cycle and the word they showed
  logic [NumFifos-1:0] heldValid;
  logic [NumFifos-1:0][Width-1:0] heldData;

  sharedMultiFifo dut0 (
    .clk, .rst, .push, .pushCredit, .pushFull, .receiverInReset,
    .popValid, .popReady, .popData
  );

  bind sharedMultiFifo sharedMultiFifoAssertions asserts0 (
    .clk, .rst, .push, .pushFull, .popValid, .popReady, .popData, .request, .grant, .dealloc
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // Plain LCG with the usual 32-bit constants
  // Its upper bits are the better ones
  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic int sumPushes();
    int total;
    total = 0;
    for (int i = 0; i < NumRows; i++) begin
      total += rowPushes[i];
    end
    return total;
  endfunction

  task automatic compareData(string what, logic [Width-1:0] expected, logic [Width-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s %s: expected %0h actual %0h", curTest, what, expected, actual);
    end
  endtask

  task automatic compareCount(string what, int expected, int actual);
    checks++;
    if (actual != expected) begin
      errors++;
      $display("mismatch %s %s: expected %0d actual %0d", curTest, what, expected, actual);
    end
  endtask

  task automatic compareFlags(string what, logic [NumFifos-1:0] expected,
                              logic [NumFifos-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s %s: expected %b actual %b", curTest, what, expected, actual);
    end
  endtask

  task automatic reportProblem(string msg);
    errors++;
    $display("%s: %s", curTest, msg);
  endtask

  task automatic finishTest(int errorsBefore);
    testsRun++;
    if (errors == errorsBefore) begin
      $display("%s: ok", curTest);
    end else begin
      failedTests++;
      $display("%s: %0d errors", curTest, errors - errorsBefore);
    end
  endtask

  // One clock cycle as seen from the falling edge
  // Outputs are all registered, so they are stable here and hold until the next rising edge
  task automatic stepCycle(input int readyMode, input bit tryPush, input int selMode,
                           input int fifoSel, output bit pushed);
    logic [NumFifos-1:0] ready;
    logic [31:0] r;
    logic [FifoIdWidth-1:0] id;
    logic [Width-1:0] expected;
    @(negedge clk);
    pushed = 1'b0;
    if (pushCredit) begin
      credits++;
      totalCredits++;
      rowCredits++;
    end
    // Credits never exceed free entries, so a full freelist means an empty wallet
    if (pushFull && credits > 0) begin
      reportProblem("pushFull is high while the sender still holds credits");
    end
    for (int f = 0; f < NumFifos; f++) begin
      if (heldValid[f]) begin
        if (!popValid[f]) begin
          reportProblem($sformatf("FIFO %0d dropped popValid while stalled", f));
        end
        compareData($sformatf("held popData[%0d]", f), heldData[f], popData[f]);
      end
    end
    r = nextRand();
    if (readyMode == ReadyAlways) begin
      ready = '1;
    end else if (readyMode == ReadyNever) begin
      ready = '0;
    end else begin
      ready = r[31 -: NumFifos];
    end
    // These transfers complete at the coming rising edge
    for (int f = 0; f < NumFifos; f++) begin
      if (popValid[f] && ready[f]) begin
        if (refQ[f].size() == 0) begin
          reportProblem($sformatf("FIFO %0d offered a word that was never pushed", f));
        end else begin
          expected = refQ[f].pop_front();
          compareData($sformatf("popData[%0d]", f), expected, popData[f]);
        end
      end
    end
    heldValid = popValid & ~ready;
    heldData = popData;
    push = '0;
    if (tryPush && credits > 0) begin
      r = nextRand();
      id = (selMode == SelRandom) ? r[31 -: FifoIdWidth] : FifoIdWidth'(fifoSel);
      push.valid = 1'b1;
      push.fifoId = id;
      push.data = r[23 -: Width];
      refQ[id].push_back(push.data);
      credits--;
      totalPushes++;
      pushed = 1'b1;
    end
    popReady = ready;
  endtask

  // With popReady held low only the staged words have returned credits
  task automatic checkStalled();
    logic [NumFifos-1:0] nonEmpty;
    bit pushed;
    for (int i = 0; i < 4; i++) begin
      stepCycle(ReadyNever, 1'b0, SelFixed, 0, pushed);
    end
    for (int f = 0; f < NumFifos; f++) begin
      nonEmpty[f] = (refQ[f].size() != 0);
    end
    compareFlags("popValid while stalled", nonEmpty, popValid);
    compareCount("credit pulses while stalled", $countones(nonEmpty), rowCredits);
    compareCount("pushFull", int'(credits == 0), int'(pushFull));
  endtask

  // Pop everything until no word is expected and no stage offers one
  // An entry returns its credit as its word lands in a stage, so by then
  // every credit pulse should already have been seen
  task automatic drainAll();
    int guard;
    bit pushed;
    bit busy;
    guard = 0;
    busy = 1'b1;
    while (busy && guard < 400) begin
      stepCycle(ReadyAlways, 1'b0, SelFixed, 0, pushed);
      guard++;
      busy = (popValid != '0);
      for (int f = 0; f < NumFifos; f++) begin
        if (refQ[f].size() != 0) begin
          busy = 1'b1;
        end
      end
    end
    if (busy) begin
      reportProblem("the FIFOs did not drain");
    end
    compareCount("credits after drain", Depth, credits);
    compareCount("credit pulses against pushes", totalPushes, totalCredits);
  endtask

  // Watchdog sized from the table
  initial begin
    int limit;
    limit = sumPushes() * 20 + 200;
    repeat (limit) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    int waitCycles;
    int errorsBefore;
    int sent;
    bit pushed;
    rst = 1'b1;
    push = '0;
    popReady = '0;
    credits = 0;
    totalPushes = 0;
    totalCredits = 0;
    rowCredits = 0;
    checks = 0;
    errors = 0;
    testsRun = 0;
    failedTests = 0;
    heldValid = '0;
    heldData = '0;
    curTest = "reset";
    errorsBefore = 0;
    repeat (8) @(negedge clk);
    compareCount("receiverInReset during reset", 1, int'(receiverInReset));
    rst = 1'b0;
    waitCycles = 0;
    while (receiverInReset !== 1'b0 && waitCycles < 10) begin
      @(negedge clk);
      waitCycles++;
    end
    if (receiverInReset !== 1'b0) begin
      reportProblem("receiverInReset stayed high after reset");
    end
    // The sender reloads its credits once the receiver is out of reset
    credits = Depth;
    compareFlags("popValid after reset", '0, popValid);
    compareCount("pushFull after reset", 0, int'(pushFull));
    compareCount("pushCredit after reset", 0, int'(pushCredit));
    for (int i = 0; i < 4; i++) begin
      stepCycle(ReadyAlways, 1'b0, SelFixed, 0, pushed);
    end
    compareCount("credit pulses after reset", 0, totalCredits);
    finishTest(errorsBefore);

    for (int row = 0; row < NumRows; row++) begin
      curTest = rowName[row];
      errorsBefore = errors;
      rowCredits = 0;
      sent = 0;
      // A push only goes out while a credit is held, so this waits on returned credits
      while (sent < rowPushes[row]) begin
        stepCycle(rowReady[row], 1'b1, rowSel[row],
                  (rowSel[row] == SelCycle) ? sent : rowFixedId[row], pushed);
        if (pushed) begin
          sent++;
        end
      end
      if (rowReady[row] == ReadyNever) begin
        checkStalled();
      end
      if (rowDrain[row]) begin
        drainAll();
      end
      finishTest(errorsBefore);
    end

    $display("tests %0d, failed %0d, checks %0d, errors %0d", testsRun, failedTests, checks,
             errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* tests/sharedMultiFifo_assertions.sv */
`timescale 1ns/1ps

module sharedMultiFifoAssertions
  import mfifoPkg::*;
(
  input logic                           clk,
  input logic                           rst,
  input pushReqT                        push,
  input logic                           pushFull,
  input logic [NumFifos-1:0]            popValid,
  input logic [NumFifos-1:0]            popReady,
  input logic [NumFifos-1:0][Width-1:0] popData,
  input logic [NumFifos-1:0]            request,
  input logic [NumFifos-1:0]            grant,
  input deallocT                        dealloc
);

  // A sender that honors its credits can never push into an empty freelist
  noPushWhenFull: assert property (@(posedge clk) disable iff (rst)
    !(push.valid && pushFull))
    else $error("push.valid high while pushFull is high");

  // A stalled stage keeps offering the same word until it is taken
  for (genvar f = 0; f < NumFifos; f++) begin : gStall
    stallHolds: assert property (@(posedge clk) disable iff (rst)
      (popValid[f] && !popReady[f]) |=> (popValid[f] && $stable(popData[f])))
      else $error("FIFO %0d changed its pop output while stalled", f);
  end

  // At most one winner, and only among the stages that asked
  grantLegal: assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant) && ((grant & ~request) == '0))
    else $error("grant is not one-hot or lies outside request");

  // Reset clears the read in flight, so nothing is freed while it is held
  noDeallocInReset: assert property (@(posedge clk) rst |=> !dealloc.valid)
    else $error("dealloc.valid high during reset");

endmodule

/* hw/sharedMultiFifo.sv */
`timescale 1ns/1ps

module sharedMultiFifo
  import mfifoPkg::*;
(
  input  logic                           clk,
  input  logic                           rst,
  input  pushReqT                        push,
  output logic                           pushCredit,
  output logic                           pushFull,
  output logic                           receiverInReset,
  output logic [NumFifos-1:0]            popValid,
  input  logic [NumFifos-1:0]            popReady,
  output logic [NumFifos-1:0][Width-1:0] popData
);

  // Input side to linked lists
  appendT append;
  // Linked lists to output side
  logic [NumFifos-1:0] headValid;
  logic [NumFifos-1:0][AddrWidth-1:0] head;
  logic [NumFifos-1:0] headTake;
  // Arbitration for the single RAM read port
  logic [NumFifos-1:0] request;
  logic [NumFifos-1:0] grant;
  logic enableUpdate;
  // Data RAM ports
  logic wrValid;
  logic [AddrWidth-1:0] wrAddr;
  logic [Width-1:0] wrData;
  logic rdValid;
  logic [AddrWidth-1:0] rdAddr;
  logic [Width-1:0] rdData;
  // Freed entries back to the freelist
  deallocT dealloc;

  pushCreditCtrl pushCtrl0 (
    .clk, .rst, .push, .dealloc, .pushCredit, .pushFull, .receiverInReset,
    .append, .wrValid, .wrAddr, .wrData
  );

  linkedListMgr listMgr0 (
    .clk, .rst, .append, .headTake, .headValid, .head
  );

  popStagingCtrl popCtrl0 (
    .clk, .rst, .headValid, .head, .grant, .request, .enableUpdate, .headTake,
    .rdValid, .rdAddr, .rdData, .dealloc, .popValid, .popReady, .popData
  );

  rrArbiter arb0 (
    .clk, .rst, .request, .enableUpdate, .grant
  );

  dataRam ram0 (
    .clk, .wrValid, .wrAddr, .wrData, .rdValid, .rdAddr, .rdData
  );

endmodule

/* hw/popStagingCtrl.sv */
`timescale 1ns/1ps

module popStagingCtrl
  import mfifoPkg::*;
(
  input  logic                               clk,
  input  logic                               rst,
  input  logic [NumFifos-1:0]                headValid,
  input  logic [NumFifos-1:0][AddrWidth-1:0] head,
  input  logic [NumFifos-1:0]                grant,
  output logic [NumFifos-1:0]                request,
  output logic                               enableUpdate,
  output logic [NumFifos-1:0]                headTake,
  output logic                               rdValid,
  output logic [AddrWidth-1:0]               rdAddr,
  input  logic [Width-1:0]                   rdData,
  output deallocT                            dealloc,
  output logic [NumFifos-1:0]                popValid,
  input  logic [NumFifos-1:0]                popReady,
  output logic [NumFifos-1:0][Width-1:0]     popData
);

  // One-entry staging buffer per FIFO
  stageStateT state [NumFifos];
  logic [NumFifos-1:0][Width-1:0] stageData;
  // Binary index of the granted FIFO
  logic [FifoIdWidth-1:0] grantId;
  logic anyGrant;
  // Read in flight to the data RAM, one cycle deep
  logic pendValid;
  logic [FifoIdWidth-1:0] pendFifo;
  logic [AddrWidth-1:0] pendAddr;

  always_comb begin
    grantId = '0;
    for (int f = 0; f < NumFifos; f++) begin
      if (grant[f]) begin
        grantId = FifoIdWidth'(f);
      end
    end
  end

  assign anyGrant = |grant;

  // A stage asks for the RAM port when it is idle and has data waiting
  always_comb begin
    for (int f = 0; f < NumFifos; f++) begin
      request[f] = (state[f] == StageEmpty) && headValid[f];
      popValid[f] = (state[f] == StageFull);
    end
  end

  // The winner's head is read and unlinked in the same cycle
  assign headTake = grant;
  assign rdValid = anyGrant;
  assign rdAddr = head[grantId];
  // Rotate priority only when the port was actually used
  assign enableUpdate = anyGrant;

  // Entry goes back to the freelist as its data lands in the stage
  assign dealloc.valid = pendValid;
  assign dealloc.entry = pendAddr;

  assign popData = stageData;

  // Track the outstanding read
  always_ff @(posedge clk) begin
    if (rst) begin
      pendValid <= 1'b0;
    end else begin
      pendValid <= anyGrant;
    end
  end

  always_ff @(posedge clk) begin
    if (anyGrant) begin
      pendFifo <= grantId;
      pendAddr <= head[grantId];
    end
  end

  // Stage state machines
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int f = 0; f < NumFifos; f++) begin
        state[f] <= StageEmpty;
      end
    end else begin
      for (int f = 0; f < NumFifos; f++) begin
        case (state[f])
          StageEmpty: begin
            if (grant[f]) begin
              state[f] <= StageFetching;
            end
          end
          StageFetching: begin
            // RAM latency is one cycle, so data is due now
            if (pendValid && (pendFifo == FifoIdWidth'(f))) begin
              state[f] <= StageFull;
            end
          end
          StageFull: begin
            // Held here while popReady is low
            if (popReady[f]) begin
              state[f] <= StageEmpty;
            end
          end
          default: begin
            state[f] <= StageEmpty;
          end
        endcase
      end
    end
  end

  // Capture the read data into the stage that asked for it
  always_ff @(posedge clk) begin
    if (pendValid) begin
      stageData[pendFifo] <= rdData;
    end
  end

endmodule

/* hw/linkedListMgr.sv */
`timescale 1ns/1ps

module linkedListMgr
  import mfifoPkg::*;
(
  input  logic                                 clk,
  input  logic                                 rst,
  input  appendT                               append,
  input  logic [NumFifos-1:0]                  headTake,
  output logic [NumFifos-1:0]                  headValid,
  output logic [NumFifos-1:0][AddrWidth-1:0]   head
);

  // Pointer RAM, one next address per entry, read without latency
  logic [AddrWidth-1:0] nextPtr [Depth];
  logic [NumFifos-1:0][AddrWidth-1:0] tail;
  logic [NumFifos-1:0][CountWidth-1:0] count;
  // Append is addressed to this FIFO
  logic [NumFifos-1:0] appendHit;
  // The appended entry becomes the new head of this FIFO
  logic [NumFifos-1:0] newHead;
  // The old tail is a live entry of the target list and gets linked
  logic ptrWrite;

  always_comb begin
    for (int f = 0; f < NumFifos; f++) begin
      appendHit[f] = append.valid && (append.fifoId == FifoIdWidth'(f));
      headValid[f] = (count[f] != '0);
      // Empty now, or its last item leaves in this very cycle
      newHead[f] = (count[f] == '0) || ((count[f] == CountWidth'(1)) && headTake[f]);
    end
  end

  // An empty list has a stale tail that may already belong to another
  // FIFO, so its pointer must not be touched
  assign ptrWrite = append.valid && headValid[append.fifoId];

  // Item counts are the only control state here
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else begin
      for (int f = 0; f < NumFifos; f++) begin
        // Append plus take on one FIFO leaves the count as it was
        count[f] <= count[f] + CountWidth'(appendHit[f]) - CountWidth'(headTake[f]);
      end
    end
  end

  // Head and tail registers follow the count
  always_ff @(posedge clk) begin
    for (int f = 0; f < NumFifos; f++) begin
      if (appendHit[f]) begin
        tail[f] <= append.entry;
      end
      if (appendHit[f] && newHead[f]) begin
        head[f] <= append.entry;
      end else if (headTake[f]) begin
        // Step along the list to the next entry
        head[f] <= nextPtr[head[f]];
      end
    end
  end

  // Link the new entry behind the current tail
  // With two or more items the head and tail differ, so this write never
  // collides with the head read above
  always_ff @(posedge clk) begin
    if (ptrWrite) begin
      nextPtr[tail[append.fifoId]] <= append.entry;
    end
  end

endmodule

/* hw/pushCreditCtrl.sv */
`timescale 1ns/1ps

module pushCreditCtrl
  import mfifoPkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  pushReqT              push,
  input  deallocT              dealloc,
  output logic                 pushCredit,
  output logic                 pushFull,
  output logic                 receiverInReset,
  output appendT               append,
  output logic                 wrValid,
  output logic [AddrWidth-1:0] wrAddr,
  output logic [Width-1:0]     wrData
);

  // Circular queue of free entry addresses
  logic [AddrWidth-1:0] freeList [Depth];
  // Next address to hand out
  logic [AddrWidth-1:0] rdPtr;
  // Slot where the next returned address is stored
  logic [AddrWidth-1:0] wrPtr;
  // Number of addresses currently in the queue
  logic [CountWidth-1:0] freeCount;
  logic [AddrWidth-1:0] allocEntry;

  // The head of the freelist is the entry a push would land in
  assign allocEntry = freeList[rdPtr];

  // Push data goes straight into the data RAM in the push cycle
  assign wrValid = push.valid;
  assign wrAddr = allocEntry;
  assign wrData = push.data;

  // The same entry is linked onto the tail of the target FIFO
  assign append.valid = push.valid;
  assign append.fifoId = push.fifoId;
  assign append.entry = allocEntry;

  // No free entry left, so the sender must be out of credits too
  assign pushFull = (freeCount == '0);

  // Freelist bookkeeping
  always_ff @(posedge clk) begin
    if (rst) begin
      // After reset every entry is free and the queue is full
      for (int i = 0; i < Depth; i++) begin
        freeList[i] <= AddrWidth'(i);
      end
      rdPtr <= '0;
      wrPtr <= '0;
      freeCount <= CountWidth'(Depth);
    end else begin
      // A push consumes the address at the read pointer
      if (push.valid) begin
        rdPtr <= rdPtr + AddrWidth'(1);
      end
      // A deallocation appends the returned address at the write pointer
      if (dealloc.valid) begin
        freeList[wrPtr] <= dealloc.entry;
        wrPtr <= wrPtr + AddrWidth'(1);
      end
      // Both may happen in one cycle and then cancel out
      freeCount <= freeCount + CountWidth'(dealloc.valid) - CountWidth'(push.valid);
    end
  end

  // Credit return, one pulse per freed entry
  always_ff @(posedge clk) begin
    if (rst) begin
      pushCredit <= 1'b0;
    end else begin
      pushCredit <= dealloc.valid;
    end
  end

  // Tells the sender when it may reload its Depth credits
  // It drops on the first cycle out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      receiverInReset <= 1'b1;
    end else begin
      receiverInReset <= 1'b0;
    end
  end

endmodule

/* hw/rrArbiter.sv */
`timescale 1ns/1ps

module rrArbiter
  import mfifoPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [NumFifos-1:0] request,
  input  logic                enableUpdate,
  output logic [NumFifos-1:0] grant
);

  // Highest priority position
  logic [FifoIdWidth-1:0] ptr;
  logic [FifoIdWidth-1:0] idx;
  logic [FifoIdWidth-1:0] winner;
  logic found;

  // Scan from the pointer and wrap, first requester wins
  always_comb begin
    grant = '0;
    winner = ptr;
    found = 1'b0;
    idx = ptr;
    for (int i = 0; i < NumFifos; i++) begin
      // Index wraps naturally since NumFifos is a power of two
      idx = ptr + FifoIdWidth'(i);
      if (!found && request[idx]) begin
        found = 1'b1;
        winner = idx;
        grant[idx] = 1'b1;
      end
    end
  end

  // The winner drops to lowest priority once its grant is used
  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (enableUpdate && found) begin
      ptr <= winner + FifoIdWidth'(1);
    end
  end

endmodule

/* hw/dataRam.sv */
`timescale 1ns/1ps

module dataRam
  import mfifoPkg::*;
(
  input  logic                 clk,
  input  logic                 wrValid,
  input  logic [AddrWidth-1:0] wrAddr,
  input  logic [Width-1:0]     wrData,
  input  logic                 rdValid,
  input  logic [AddrWidth-1:0] rdAddr,
  output logic [Width-1:0]     rdData
);

  logic [Width-1:0] mem [Depth];

  always_ff @(posedge clk) begin
    if (wrValid) begin
      mem[wrAddr] <= wrData;
    end
  end

  // Registered read, data shows up the cycle after the address
  always_ff @(posedge clk) begin
    if (rdValid) begin
      rdData <= mem[rdAddr];
    end
  end

endmodule

/* hw/mfifoPkg.sv */
package mfifoPkg;

  // Number of logical FIFOs sharing the storage
  localparam int NumFifos = 4;
  // Entries in the shared data RAM
  localparam int Depth = 16;
  // Payload width
  localparam int Width = 8;
  localparam int FifoIdWidth = 2;
  localparam int AddrWidth = 4;
  // Wide enough to hold Depth itself
  localparam int CountWidth = 5;

  // Push request from the sender
  typedef struct packed {
    logic valid;
    logic [FifoIdWidth-1:0] fifoId;
    logic [Width-1:0] data;
  } pushReqT;

  // Entry handed back to the freelist
  typedef struct packed {
    logic valid;
    logic [AddrWidth-1:0] entry;
  } deallocT;

  // Freshly written entry to be linked onto a FIFO tail
  typedef struct packed {
    logic valid;
    logic [FifoIdWidth-1:0] fifoId;
    logic [AddrWidth-1:0] entry;
  } appendT;

  // Pop-side staging buffer state
  typedef enum logic [1:0] {
    StageEmpty,
    StageFetching,
    StageFull
  } stageStateT;

endpackage
